// File: src/taus_pkg.sv
// Shared types and constants for the taus88 RNG; FIFO_DEPTH must stay a power of two
package taus_pkg;

    // Three taus88 component states
    typedef struct packed {
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] s3;
    } taus_state_t;

    // Byte address width of the register map
    localparam int ADR_W = 5;

    // Master side of the Wishbone classic bus
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [3:0]       sel;
        logic [31:0]      dat;
    } wb_req_t;

    // Slave side of the Wishbone classic bus
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // Register map, byte addresses
    localparam logic [ADR_W-1:0] ADR_CTRL   = 5'd0;
    localparam logic [ADR_W-1:0] ADR_STATUS = 5'd4;
    localparam logic [ADR_W-1:0] ADR_SEED1  = 5'd8;
    localparam logic [ADR_W-1:0] ADR_SEED2  = 5'd12;
    localparam logic [ADR_W-1:0] ADR_SEED3  = 5'd16;
    localparam logic [ADR_W-1:0] ADR_DATA   = 5'd20;

    // CTRL register bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_LOAD_BIT   = 1;

    // Bit forced high on seed load, keeps each component above its minimum
    localparam int SEED1_MIN_BIT = 1;
    localparam int SEED2_MIN_BIT = 3;
    localparam int SEED3_MIN_BIT = 4;

    localparam taus_state_t DEFAULT_SEED = '{s1: 32'd12345, s2: 32'd67890, s3: 32'd13579};

    // Output word buffer
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = PTR_W + 1;

endpackage

// File: src/taus_core.sv
// taus88 generator, one step per accepted word; load wins over advance in the same cycle
module taus_core import taus_pkg::*; (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        enable,
    input  logic        load,
    input  taus_state_t seed,
    input  logic        ready,
    output logic [31:0] word,
    output logic        word_valid
);

    taus_state_t state;
    taus_state_t next_state;
    taus_state_t seed_adj;
    logic        advance;

    // One taus88 step on all three components
    function automatic taus_state_t taus_step(input taus_state_t s);
        taus_state_t n;
        logic [31:0] b1;
        logic [31:0] b2;
        logic [31:0] b3;
        b1 = ((s.s1 << 13) ^ s.s1) >> 19;
        b2 = ((s.s2 << 2) ^ s.s2) >> 25;
        b3 = ((s.s3 << 3) ^ s.s3) >> 11;
        n.s1 = ((s.s1 & 32'hFFFF_FFFE) << 12) ^ b1;
        n.s2 = ((s.s2 & 32'hFFFF_FFF8) << 4) ^ b2;
        n.s3 = ((s.s3 & 32'hFFFF_FFF0) << 17) ^ b3;
        return n;
    endfunction

    assign next_state = taus_step(state);

    // Minimum rule, the masked upper part of each seed must be nonzero
    assign seed_adj.s1 = seed.s1 | (32'd1 << SEED1_MIN_BIT);
    assign seed_adj.s2 = seed.s2 | (32'd1 << SEED2_MIN_BIT);
    assign seed_adj.s3 = seed.s3 | (32'd1 << SEED3_MIN_BIT);

    // Step only when the output slot is free or being taken this cycle
    assign advance = enable && (!word_valid || ready);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= DEFAULT_SEED;
            word_valid <= 1'b0;
        end else if (load) begin
            state      <= seed_adj;
            word_valid <= 1'b0;
        end else if (advance) begin
            state      <= next_state;
            word_valid <= 1'b1;
        end else if (word_valid && ready) begin
            // Paused and the last word was taken
            word_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (advance && !load) begin
            word <= next_state.s1 ^ next_state.s2 ^ next_state.s3;
        end
    end

    // A component at or below its minimum would lock the sequence
    a_state_min: assert property (@(posedge clk_in) disable iff (reset)
        state.s1 >= (32'd1 << SEED1_MIN_BIT) &&
        state.s2 >= (32'd1 << SEED2_MIN_BIT) &&
        state.s3 >= (32'd1 << SEED3_MIN_BIT));

endmodule

// File: src/rnd_fifo.sv
// Word buffer of FIFO_DEPTH entries; flush beats a push or pop in the same cycle
module rnd_fifo import taus_pkg::*; (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               flush,
    input  logic [31:0]        wr_word,
    input  logic               wr_valid,
    output logic               ready,
    input  logic               pop,
    output logic [31:0]        rd_word,
    output logic               empty,
    output logic [LEVEL_W-1:0] level
);

    logic [31:0]      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             take;

    assign ready = (level != LEVEL_W'(FIFO_DEPTH));
    assign empty = (level == '0);
    assign push  = wr_valid && ready;
    assign take  = pop && !empty;

    // Oldest word is always on the output
    assign rd_word = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, take})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // The bus slave only pops once a word is present
    a_no_pop_empty: assert property (@(posedge clk_in) disable iff (reset)
        pop |-> !empty);

    a_level_max: assert property (@(posedge clk_in) disable iff (reset)
        level <= LEVEL_W'(FIFO_DEPTH));

endmodule

// File: src/wb_rng_regs.sv
// Wishbone classic slave; DATA reads stall until a word is buffered, no error or retry
module wb_rng_regs import taus_pkg::*; (
    input  logic               clk_in,
    input  logic               reset,
    input  wb_req_t            wb_req,
    output wb_rsp_t            wb_rsp,
    output logic               enable,
    output logic               load,
    output taus_state_t        seed,
    output logic               pop,
    input  logic [31:0]        rd_word,
    input  logic               empty,
    input  logic [LEVEL_W-1:0] level
);

    logic        ack;
    logic [31:0] rsp_dat;
    logic        is_data_rd;
    logic        accept;
    logic        wr_en;
    logic [31:0] rd_mux;

    // Byte-lane merge for seed writes
    function automatic logic [31:0] merge_sel(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign is_data_rd = !wb_req.we && (wb_req.adr == ADR_DATA);

    // New request seen and not yet answered; DATA reads wait for a word
    assign accept = wb_req.cyc && wb_req.stb && !ack && (!is_data_rd || !empty);
    assign wr_en  = accept && wb_req.we;
    assign pop    = accept && is_data_rd;

    always_comb begin
        case (wb_req.adr)
            ADR_CTRL:   rd_mux = {31'b0, enable};
            ADR_STATUS: rd_mux = {{(32 - LEVEL_W){1'b0}}, level};
            ADR_SEED1:  rd_mux = seed.s1;
            ADR_SEED2:  rd_mux = seed.s2;
            ADR_SEED3:  rd_mux = seed.s3;
            ADR_DATA:   rd_mux = rd_word;
            default:    rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ack    <= 1'b0;
            enable <= 1'b0;
            load   <= 1'b0;
            seed   <= DEFAULT_SEED;
        end else begin
            ack  <= accept;
            load <= 1'b0;
            if (wr_en) begin
                case (wb_req.adr)
                    ADR_CTRL: begin
                        if (wb_req.sel[0]) begin
                            enable <= wb_req.dat[CTRL_ENABLE_BIT];
                            load   <= wb_req.dat[CTRL_LOAD_BIT];
                        end
                    end
                    ADR_SEED1: seed.s1 <= merge_sel(seed.s1, wb_req.dat, wb_req.sel);
                    ADR_SEED2: seed.s2 <= merge_sel(seed.s2, wb_req.dat, wb_req.sel);
                    ADR_SEED3: seed.s3 <= merge_sel(seed.s3, wb_req.dat, wb_req.sel);
                    default: ;
                endcase
            end
        end
    end

    // Read data is captured on the acknowledging edge, together with the pop
    always_ff @(posedge clk_in) begin
        if (accept) begin
            rsp_dat <= wb_req.we ? 32'b0 : rd_mux;
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rsp_dat;

    // Master must hold the request until the acknowledge
    a_ack_in_cycle: assert property (@(posedge clk_in) disable iff (reset)
        ack |-> (wb_req.cyc && wb_req.stb));

endmodule

// File: src/taus_rng_top.sv
// Memory-mapped taus88 random source; single clock, synchronous active-high reset
module taus_rng_top import taus_pkg::*; (
    input  logic    clk_in,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic               enable;
    logic               load;
    taus_state_t        seed;
    logic               pop;
    logic [31:0]        rd_word;
    logic               empty;
    logic [LEVEL_W-1:0] level;
    logic [31:0]        word;
    logic               word_valid;
    logic               ready;

    wb_rng_regs i_wb_rng_regs (
        .clk_in  (clk_in),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .enable  (enable),
        .load    (load),
        .seed    (seed),
        .pop     (pop),
        .rd_word (rd_word),
        .empty   (empty),
        .level   (level)
    );

    taus_core i_taus_core (
        .clk_in     (clk_in),
        .reset      (reset),
        .enable     (enable),
        .load       (load),
        .seed       (seed),
        .ready      (ready),
        .word       (word),
        .word_valid (word_valid)
    );

    // Load also drops every buffered word
    rnd_fifo i_rnd_fifo (
        .clk_in   (clk_in),
        .reset    (reset),
        .flush    (load),
        .wr_word  (word),
        .wr_valid (word_valid),
        .ready    (ready),
        .pop      (pop),
        .rd_word  (rd_word),
        .empty    (empty),
        .level    (level)
    );

endmodule

// File: test/tb_wb_tasks.svh
// Needs clk_in, wb_req, wb_rsp and DRIVE_DLY declared in the including module
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// Classic cycle with the request held through the edge that samples ack
task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                         input logic [31:0] wdat, output logic [31:0] rdat);
    @(posedge clk_in);
    #DRIVE_DLY;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.sel = 4'hF;
    wb_req.dat = wdat;
    do begin
        @(posedge clk_in);
        #DRIVE_DLY;
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(posedge clk_in);
    #DRIVE_DLY;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
endtask

task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [31:0] wdat);
    logic [31:0] discard;
    bus_cycle(1'b1, adr, wdat, discard);
endtask

task automatic read_reg(input logic [ADR_W-1:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, 32'd0, rdat);
endtask

function automatic logic [31:0] next_xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Tausworthe component with generator parameters k, q and s
function automatic logic [31:0] taus_component(input logic [31:0] z, input int k,
                                               input int q, input int s);
    logic [31:0] mask;
    logic [31:0] b;
    mask = 32'hFFFF_FFFF << (32 - k);
    b    = ((z << q) ^ z) >> (k - s);
    return ((z & mask) << s) ^ b;
endfunction

function automatic taus_state_t ref_step(input taus_state_t st);
    taus_state_t n;
    n.s1 = taus_component(st.s1, 31, 13, 12);
    n.s2 = taus_component(st.s2, 29, 2, 4);
    n.s3 = taus_component(st.s3, 28, 3, 17);
    return n;
endfunction

function automatic logic [31:0] combine(input taus_state_t st);
    return st.s1 ^ st.s2 ^ st.s3;
endfunction

// Seeds as the core stores them on load with the values 2, 8 and 16 forced in
function automatic taus_state_t adjust_seed(input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] c);
    taus_state_t st;
    st.s1 = a | 32'h0000_0002;
    st.s2 = b | 32'h0000_0008;
    st.s3 = c | 32'h0000_0010;
    return st;
endfunction

`endif

// File: test/tb_taus_rng.sv
// Self-checking testbench for taus_rng_top; needs timing support, reads and writes no files
module tb_taus_rng import taus_pkg::*; ();

    localparam int DRIVE_DLY = 5;
    // About 300 accesses of under 10 cycles each plus about 100 wait cycles
    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] CTRL_RUN      = 32'(1) << CTRL_ENABLE_BIT;
    localparam logic [31:0] CTRL_LOAD_RUN = CTRL_RUN | (32'(1) << CTRL_LOAD_BIT);

    logic        clk_in;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] rd_val;
    logic [31:0] rng_state;
    logic [31:0] seed_a;
    logic [31:0] seed_b;
    logic [31:0] seed_c;
    string       test_name;
    int          reg_errors;
    // Handoff from the stimulus to the compare process
    logic [31:0] last_word;
    string       word_test;
    int          reads_done;
    taus_state_t load_state;
    int          load_count;
    // Owned by the compare process
    taus_state_t model;
    logic [31:0] exp_word;
    int          reads_checked = 0;
    int          loads_seen = 0;
    int          word_errors = 0;
    int          cycles = 0;

    `include "tb_wb_tasks.svh"

    taus_rng_top i_taus_rng_top (
        .clk_in (clk_in),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s: expected %08h, actual %08h", test_name, expected, actual);
            reg_errors++;
        end
    endtask

    task automatic read_words(input int count);
        for (int i = 0; i < count; i++) begin
            read_reg(ADR_DATA, last_word);
            word_test = test_name;
            reads_done++;
        end
    endtask

    task automatic load_seeds(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        write_reg(ADR_SEED1, a);
        write_reg(ADR_SEED2, b);
        write_reg(ADR_SEED3, c);
        write_reg(ADR_CTRL, CTRL_LOAD_RUN);
        load_state = adjust_seed(a, b, c);
        load_count++;
    endtask

    // Each read word is compared with the next model word on the following edge
    always @(posedge clk_in) begin
        if (loads_seen != load_count) begin
            model      = load_state;
            loads_seen = load_count;
        end
        if (reads_checked != reads_done) begin
            model    = ref_step(model);
            exp_word = combine(model);
            assert (last_word == exp_word) else begin
                $display("[ERROR] %s: expected %08h, actual %08h", word_test, exp_word, last_word);
                word_errors++;
            end
            reads_checked = reads_done;
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        wb_req     = '0;
        reset      = 1'b1;
        reg_errors = 0;
        reads_done = 0;
        rng_state  = 32'd28;
        load_state = DEFAULT_SEED;
        load_count = 1;
        test_name  = "reset_state";
        repeat (2) @(posedge clk_in);
        #DRIVE_DLY;
        reset = 1'b0;

        read_reg(ADR_CTRL, rd_val);
        check_value(32'd0, rd_val);
        read_reg(ADR_STATUS, rd_val);
        check_value(32'd0, rd_val);
        write_reg(ADR_CTRL, CTRL_RUN);
        read_words(10);

        test_name = "seed_load";
        load_seeds(32'h1234_5678, 32'h9ABC_DEF0, 32'h0F0F_F0F0);
        read_words(20);
        read_reg(ADR_SEED1, rd_val);
        check_value(32'h1234_5678, rd_val);
        read_reg(ADR_SEED2, rd_val);
        check_value(32'h9ABC_DEF0, rd_val);
        read_reg(ADR_SEED3, rd_val);
        check_value(32'h0F0F_F0F0, rd_val);

        test_name = "low_seeds";
        load_seeds(32'd0, 32'd5, 32'd3);
        read_words(16);

        test_name = "back_pressure";
        repeat (50) @(posedge clk_in);
        read_reg(ADR_STATUS, rd_val);
        check_value(32'(FIFO_DEPTH), rd_val);
        read_words(30);

        test_name = "pause";
        repeat (20) @(posedge clk_in);
        write_reg(ADR_CTRL, 32'd0);
        repeat (20) @(posedge clk_in);
        read_reg(ADR_STATUS, rd_val);
        check_value(32'(FIFO_DEPTH), rd_val);
        read_words(FIFO_DEPTH);
        // Only the word the core was holding refills the buffer while paused
        read_reg(ADR_STATUS, rd_val);
        check_value(32'd1, rd_val);

        test_name = "flush";
        write_reg(ADR_CTRL, CTRL_RUN);
        read_words(4);
        load_seeds(32'hDEAD_BEEF, 32'h0000_0042, 32'hCAFE_0001);
        read_words(16);

        test_name = "random_seeds";
        for (int round = 0; round < 5; round++) begin
            rng_state = next_xorshift(rng_state);
            seed_a    = rng_state;
            rng_state = next_xorshift(rng_state);
            seed_b    = rng_state;
            rng_state = next_xorshift(rng_state);
            seed_c    = rng_state;
            load_seeds(seed_a, seed_b, seed_c);
            read_words(16);
        end

        // Give the compare process the edge for the last word
        @(posedge clk_in);
        #DRIVE_DLY;
        $display("Done: %0d word errors, %0d register errors, %0d words checked",
                 word_errors, reg_errors, reads_checked);
        if (word_errors == 0 && reg_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: taus_rng.f
+incdir+test
src/taus_pkg.sv
src/taus_core.sv
src/rnd_fifo.sv
src/wb_rng_regs.sv
src/taus_rng_top.sv
test/tb_taus_rng.sv

// File: run_sim.sh
#!/bin/sh
# Builds the taus_rng testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
    --top-module tb_taus_rng -o tb_taus_rng -f taus_rng.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_taus_rng > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1
